/* all.f */
common/alu_pkg.sv
alu_core/alu_adder.sv
alu_core/alu_shifter.sv
alu_core/alu_bitcount.sv
alu_core/alu_core.sv
logic/wb_alu_regs.sv
logic/alu_top.sv
verification/tb_alu_top.sv

/* Makefile */
# Verilator build and run of the ALU peripheral testbench

VERILATOR ?= verilator
TOP       ?= tb_alu_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_alu_top.sv */
`default_nettype none

module tb_alu_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ACK_TIMEOUT = 20;

  logic             clk;
  logic             rst_n;
  alu_pkg::wb_req_t wb_req;
  alu_pkg::wb_rsp_t wb_rsp;
  logic             req;
  int               check_errors = 0;
  int               protocol_errors = 0;
  int               timeouts = 0;

  alu_top #(.XLEN(32)) dut0 (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  always #20ns clk = ~clk;

  assign req = wb_req.cyc & wb_req.stb;

  // --------------------------------------------------
  // Bus protocol checks
  // --------------------------------------------------
  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    (req && !wb_rsp.ack) |=> wb_rsp.ack)
    else begin
      protocol_errors++;
      $display("Protocol error at %0t: no ack one cycle after a request", $time);
    end

  ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      protocol_errors++;
      $display("Protocol error at %0t: ack stayed high for two cycles", $time);
    end

  ack_has_req: assert property (@(posedge clk) disable iff (!rst_n) wb_rsp.ack |-> $past(req))
    else begin
      protocol_errors++;
      $display("Protocol error at %0t: ack without a request one cycle earlier", $time);
    end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [31:0] leading_zeros(input logic [31:0] v);
    int n;
    n = 0;
    while (n < 32 && !v[31-n]) n++;
    return 32'(n);
  endfunction

  function automatic logic [31:0] trailing_zeros(input logic [31:0] v);
    int n;
    n = 0;
    while (n < 32 && !v[n]) n++;
    return 32'(n);
  endfunction

  function automatic logic [31:0] expected_result(input logic [4:0] op, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic lts;
    logic ltu;
    lts = $signed(a) < $signed(b);
    ltu = a < b;
    case (op)
      alu_pkg::ADD:   return a + b;
      alu_pkg::SUB:   return a - b;
      alu_pkg::AND_L: return a & b;
      alu_pkg::OR_L:  return a | b;
      alu_pkg::XOR_L: return a ^ b;
      alu_pkg::ANDN:  return a & ~b;
      alu_pkg::ORN:   return a | ~b;
      alu_pkg::XNOR:  return ~(a ^ b);
      alu_pkg::SLL:   return a << b[4:0];
      alu_pkg::SRL:   return a >> b[4:0];
      alu_pkg::SRA:   return $signed(a) >>> b[4:0];
      alu_pkg::SLTS:  return {31'b0, lts};
      alu_pkg::SLTU:  return {31'b0, ltu};
      alu_pkg::MIN:   return lts ? a : b;
      alu_pkg::MAX:   return lts ? b : a;
      alu_pkg::MINU:  return ltu ? a : b;
      alu_pkg::MAXU:  return ltu ? b : a;
      alu_pkg::CLZ:   return leading_zeros(a);
      alu_pkg::CTZ:   return trailing_zeros(a);
      alu_pkg::CPOP:  return 32'($countones(a));
      // Branches and illegal codes
      default:        return '0;
    endcase
  endfunction

  function automatic logic expected_branch(input logic [4:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
    case (op)
      alu_pkg::EQ:  return a == b;
      alu_pkg::NE:  return a != b;
      alu_pkg::LTS: return $signed(a) < $signed(b);
      alu_pkg::LTU: return a < b;
      alu_pkg::GES: return $signed(a) >= $signed(b);
      alu_pkg::GEU: return a >= b;
      default:      return 1'b0;
    endcase
  endfunction

  // --------------------------------------------------
  // Bus tasks
  // --------------------------------------------------
  task automatic finish_run();
    $display("Errors: %0d check, %0d protocol, %0d timeout",
             check_errors, protocol_errors, timeouts);
    if (check_errors + protocol_errors + timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Called 2 ns after a rising edge, returns at the same offset
  task automatic bus_access(input logic we, input logic [4:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata = '0;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata, sel: 4'hF};
    do begin
      @(posedge clk);
      #2;
      waited++;
    end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
    if (!wb_rsp.ack) begin
      timeouts++;
      $display("Timeout at %0t: no ack for address %h within %0d cycles",
               $time, adr, ACK_TIMEOUT);
      finish_run();
    end else begin
      rdata = wb_rsp.dat;
      wb_req = '0;
    end
  endtask

  task automatic write_reg(input logic [4:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic read_reg(input logic [4:0] adr, output logic [31:0] data);
    bus_access(1'b0, adr, '0, data);
  endtask

  task automatic run_op(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] rd;
    write_reg(alu_pkg::REG_OPA, a);
    write_reg(alu_pkg::REG_OPB, b);
    write_reg(alu_pkg::REG_OP, {27'b0, op});
    read_reg(alu_pkg::REG_RESULT, rd);
    check_value($sformatf("result of op %0d on %h, %h", op, a, b), rd,
                expected_result(op, a, b));
    read_reg(alu_pkg::REG_BRANCH, rd);
    check_value($sformatf("branch flag of op %0d on %h, %h", op, a, b), rd,
                {31'b0, expected_branch(op, a, b)});
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    logic [31:0] a;
    logic [31:0] rd;
    void'($urandom(32'he1cc7bd0));
    clk = 1'b0;
    rst_n = 1'b0;
    wb_req = '0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Idle bus and cleared registers after reset
    check_value("ack before first request", {31'b0, wb_rsp.ack}, 32'h0);
    read_reg(alu_pkg::REG_RESULT, rd);
    check_value("result after reset", rd, 32'h0);

    for (int c = alu_pkg::ADD; c <= alu_pkg::XNOR; c++) begin
      run_op(5'(c), 32'hFFFF_FFFF, 32'h0000_0001);
      repeat (5) run_op(5'(c), $urandom, $urandom);
    end

    // Shift amounts cover both ends
    for (int c = alu_pkg::SLL; c <= alu_pkg::SRA; c++) begin
      run_op(5'(c), 32'h8765_4321, 32'd0);
      run_op(5'(c), 32'h8765_4321, 32'd31);
      run_op(5'(c), 32'hF000_00F0, 32'hFFFF_FFE4);
      repeat (5) run_op(5'(c), $urandom, $urandom);
    end

    // Equal operands and a sign flip per compare
    for (int c = alu_pkg::SLTS; c <= alu_pkg::GEU; c++) begin
      a = $urandom;
      run_op(5'(c), a, a);
      run_op(5'(c), a, a ^ 32'h8000_0000);
      run_op(5'(c), 32'h8000_0000, 32'h7FFF_FFFF);
      repeat (4) run_op(5'(c), $urandom, $urandom);
    end

    for (int c = alu_pkg::CLZ; c <= alu_pkg::CPOP; c++) begin
      run_op(5'(c), 32'h0, 32'h0);
      run_op(5'(c), 32'hFFFF_FFFF, 32'h0);
      run_op(5'(c), 32'h0001_0000, 32'h0);
      repeat (5) run_op(5'(c), $urandom >> ($urandom % 32), $urandom);
    end

    // Register read back, ignored result write, illegal code
    run_op(alu_pkg::ADD, 32'h1234_5678, 32'h0F0F_0F0F);
    read_reg(alu_pkg::REG_OPA, rd);
    check_value("operand A read back", rd, 32'h1234_5678);
    read_reg(alu_pkg::REG_OPB, rd);
    check_value("operand B read back", rd, 32'h0F0F_0F0F);
    write_reg(alu_pkg::REG_RESULT, 32'hDEAD_BEEF);
    read_reg(alu_pkg::REG_RESULT, rd);
    check_value("result after write to result", rd, 32'h2143_6587);
    write_reg(alu_pkg::REG_OP, 32'd27);
    read_reg(alu_pkg::REG_OP, rd);
    check_value("illegal op read back", rd, 32'd27);
    run_op(5'd30, $urandom, $urandom);

    finish_run();
  end

endmodule

`default_nettype wire

/* logic/alu_top.sv */
`default_nettype none

module alu_top #(
  parameter int unsigned XLEN = 32
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  alu_pkg::wb_req_t wb_req_i,
  output alu_pkg::wb_rsp_t wb_rsp_o
);

  logic [XLEN-1:0]   opa;
  logic [XLEN-1:0]   opb;
  alu_pkg::alu_op_e  op;
  logic [XLEN-1:0]   result;
  logic              branch_taken;

  // Bus side register block
  wb_alu_regs #(
    .XLEN (XLEN)
  ) u_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .wb_req_i       (wb_req_i),
    .wb_rsp_o       (wb_rsp_o),
    .opa_o          (opa),
    .opb_o          (opb),
    .op_o           (op),
    .result_i       (result),
    .branch_taken_i (branch_taken)
  );

  // Purely combinational datapath
  alu_core #(
    .XLEN (XLEN)
  ) u_core (
    .opa_i          (opa),
    .opb_i          (opb),
    .op_i           (op),
    .result_o       (result),
    .branch_taken_o (branch_taken)
  );

endmodule

`default_nettype wire

/* logic/wb_alu_regs.sv */
`default_nettype none

module wb_alu_regs #(
  parameter int unsigned XLEN = alu_pkg::ALU_XLEN_DEFAULT
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  alu_pkg::wb_req_t wb_req_i,
  output alu_pkg::wb_rsp_t wb_rsp_o,
  output logic [XLEN-1:0]  opa_o,
  output logic [XLEN-1:0]  opb_o,
  output alu_pkg::alu_op_e op_o,
  input  logic [XLEN-1:0]  result_i,
  input  logic             branch_taken_i
);

  logic             req;
  logic             access;
  logic             wr_en;
  logic             ack_q;
  logic [31:0]      rdata_d;
  logic [31:0]      rdata_q;
  logic [XLEN-1:0]  opa_q;
  logic [XLEN-1:0]  opb_q;
  alu_pkg::alu_op_e op_q;

  assign req    = wb_req_i.cyc & wb_req_i.stb;
  // No new access in the ack cycle itself
  assign access = req & ~ack_q;
  assign wr_en  = access & wb_req_i.we;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // --------------------------------------------------
  // Operand and operation registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      opa_q <= '0;
      opb_q <= '0;
      op_q  <= alu_pkg::ADD;
    end else if (wr_en) begin
      case (wb_req_i.adr)
        alu_pkg::REG_OPA: begin
          for (int b = 0; b < 4; b++) begin
            if (wb_req_i.sel[b]) opa_q[8*b +: 8] <= wb_req_i.dat[8*b +: 8];
          end
        end
        alu_pkg::REG_OPB: begin
          for (int b = 0; b < 4; b++) begin
            if (wb_req_i.sel[b]) opb_q[8*b +: 8] <= wb_req_i.dat[8*b +: 8];
          end
        end
        // Op code lives in byte lane 0
        alu_pkg::REG_OP: begin
          if (wb_req_i.sel[0]) op_q <= alu_pkg::alu_op_e'(wb_req_i.dat[4:0]);
        end
        default: ;
      endcase
    end
  end

  // Read mux, result and flag sampled at the request edge
  always_comb begin
    rdata_d = '0;
    case (wb_req_i.adr)
      alu_pkg::REG_OPA:    rdata_d = opa_q[31:0];
      alu_pkg::REG_OPB:    rdata_d = opb_q[31:0];
      alu_pkg::REG_OP:     rdata_d = {27'b0, op_q};
      alu_pkg::REG_RESULT: rdata_d = result_i[31:0];
      alu_pkg::REG_BRANCH: rdata_d = {31'b0, branch_taken_i};
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (access && !wb_req_i.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};
  assign opa_o    = opa_q;
  assign opb_o    = opb_q;
  assign op_o     = op_q;

  // Ack is a one-cycle pulse
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i) ack_q |=> !ack_q)
    else $error("wb_alu_regs: ack high for two cycles");

  // Every ack answers a request seen one cycle earlier
  a_ack_req: assert property (@(posedge clk_i) disable iff (!rst_n_i) ack_q |-> $past(req))
    else $error("wb_alu_regs: ack without a preceding request");

endmodule

`default_nettype wire

/* alu_core/alu_core.sv */
`default_nettype none

module alu_core #(
  parameter int unsigned XLEN = alu_pkg::ALU_XLEN_DEFAULT
) (
  input  logic [XLEN-1:0]  opa_i,
  input  logic [XLEN-1:0]  opb_i,
  input  alu_pkg::alu_op_e op_i,
  output logic [XLEN-1:0]  result_o,
  output logic             branch_taken_o
);

  localparam int unsigned SW = $clog2(XLEN);
  localparam int unsigned CW = $clog2(XLEN) + 1;

  alu_pkg::alu_ctrl_t ctrl;
  logic [XLEN-1:0]    sum;
  logic [XLEN-1:0]    opb_neg;
  logic               less;
  logic [XLEN-1:0]    shift;
  logic [CW-1:0]      clz;
  logic [CW-1:0]      cpop;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  always_comb begin
    ctrl = '{negate_b: 1'b0, is_signed: 1'b0, shift_left: 1'b0, shift_arith: 1'b0,
             count_trailing: 1'b0, res_grp: alu_pkg::GRP_ZERO};
    case (op_i)
      alu_pkg::ADD: ctrl.res_grp = alu_pkg::GRP_ADDER;
      alu_pkg::SUB: begin
        ctrl.negate_b = 1'b1;
        ctrl.res_grp  = alu_pkg::GRP_ADDER;
      end
      alu_pkg::AND_L, alu_pkg::OR_L, alu_pkg::XOR_L: ctrl.res_grp = alu_pkg::GRP_LOGIC;
      alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR: begin
        ctrl.negate_b = 1'b1;
        ctrl.res_grp  = alu_pkg::GRP_LOGIC;
      end
      alu_pkg::SLL: begin
        ctrl.shift_left = 1'b1;
        ctrl.res_grp    = alu_pkg::GRP_SHIFT;
      end
      alu_pkg::SRL: ctrl.res_grp = alu_pkg::GRP_SHIFT;
      alu_pkg::SRA: begin
        ctrl.shift_arith = 1'b1;
        ctrl.res_grp     = alu_pkg::GRP_SHIFT;
      end
      alu_pkg::SLTS: begin
        ctrl.is_signed = 1'b1;
        ctrl.res_grp   = alu_pkg::GRP_SLT;
      end
      alu_pkg::SLTU: ctrl.res_grp = alu_pkg::GRP_SLT;
      alu_pkg::MIN: begin
        ctrl.is_signed = 1'b1;
        ctrl.res_grp   = alu_pkg::GRP_MIN;
      end
      alu_pkg::MINU: ctrl.res_grp = alu_pkg::GRP_MIN;
      alu_pkg::MAX: begin
        ctrl.is_signed = 1'b1;
        ctrl.res_grp   = alu_pkg::GRP_MAX;
      end
      alu_pkg::MAXU: ctrl.res_grp = alu_pkg::GRP_MAX;
      // Branches leave the result at zero, equality works on a - b
      alu_pkg::EQ, alu_pkg::NE: ctrl.negate_b = 1'b1;
      alu_pkg::LTS, alu_pkg::GES: ctrl.is_signed = 1'b1;
      alu_pkg::CLZ, alu_pkg::CPOP: ctrl.res_grp = alu_pkg::GRP_COUNT;
      alu_pkg::CTZ: begin
        ctrl.count_trailing = 1'b1;
        ctrl.res_grp        = alu_pkg::GRP_COUNT;
      end
      default: ;
    endcase
  end

  alu_adder #(.XLEN(XLEN)) u_adder (
    .opa_i          (opa_i),
    .opb_i          (opb_i),
    .ctrl_i         (ctrl),
    .op_i           (op_i),
    .sum_o          (sum),
    .opb_neg_o      (opb_neg),
    .less_o         (less),
    .branch_taken_o (branch_taken_o)
  );

  alu_shifter #(.XLEN(XLEN)) u_shifter (
    .opa_i   (opa_i),
    .shamt_i (opb_i[SW-1:0]),
    .ctrl_i  (ctrl),
    .shift_o (shift)
  );

  alu_bitcount #(.XLEN(XLEN)) u_bitcount (
    .opa_i  (opa_i),
    .ctrl_i (ctrl),
    .clz_o  (clz),
    .cpop_o (cpop)
  );

  // --------------------------------------------------
  // Result select
  // --------------------------------------------------
  always_comb begin
    case (ctrl.res_grp)
      alu_pkg::GRP_ADDER: result_o = sum;
      alu_pkg::GRP_LOGIC: begin
        if (op_i == alu_pkg::AND_L || op_i == alu_pkg::ANDN) result_o = opa_i & opb_neg;
        else if (op_i == alu_pkg::OR_L || op_i == alu_pkg::ORN) result_o = opa_i | opb_neg;
        else result_o = opa_i ^ opb_neg;
      end
      alu_pkg::GRP_SHIFT: result_o = shift;
      alu_pkg::GRP_SLT:   result_o = {{(XLEN-1){1'b0}}, less};
      alu_pkg::GRP_MIN:   result_o = less ? opa_i : opb_i;
      alu_pkg::GRP_MAX:   result_o = less ? opb_i : opa_i;
      alu_pkg::GRP_COUNT: begin
        result_o = {{(XLEN-CW){1'b0}}, (op_i == alu_pkg::CPOP) ? cpop : clz};
      end
      default:            result_o = '0;
    endcase
  end

  // Operand registers are unknown only before the first reset
  always_comb begin
    if (!$isunknown({opa_i, opb_i})) begin
      a_op_known: assert final (!$isunknown(op_i))
        else $error("alu_core: operation code is unknown");
    end
  end

endmodule

`default_nettype wire

/* alu_core/alu_bitcount.sv */
`default_nettype none

module alu_bitcount #(
  parameter int unsigned XLEN = alu_pkg::ALU_XLEN_DEFAULT
) (
  input  logic [XLEN-1:0]       opa_i,
  input  alu_pkg::alu_ctrl_t    ctrl_i,
  output logic [$clog2(XLEN):0] clz_o,
  output logic [$clog2(XLEN):0] cpop_o
);

  localparam int unsigned CW = $clog2(XLEN) + 1;

  logic [XLEN-1:0] opa_rev;
  logic [XLEN-1:0] scan;

  for (genvar k = 0; k < XLEN; k++) begin : g_rev
    assign opa_rev[k] = opa_i[XLEN-1-k];
  end

  // Trailing zeros counted as leading zeros of the reversed word
  assign scan = ctrl_i.count_trailing ? opa_rev : opa_i;

  // Highest set bit wins, empty input leaves XLEN
  always_comb begin
    clz_o = CW'(XLEN);
    for (int unsigned i = 0; i < XLEN; i++) begin
      if (scan[i]) clz_o = CW'(XLEN - 1 - i);
    end
  end

  // Population count
  always_comb begin
    cpop_o = '0;
    for (int unsigned i = 0; i < XLEN; i++) begin
      cpop_o = cpop_o + CW'(opa_i[i]);
    end
  end

endmodule

`default_nettype wire

/* alu_core/alu_shifter.sv */
`default_nettype none

module alu_shifter #(
  parameter int unsigned XLEN = alu_pkg::ALU_XLEN_DEFAULT
) (
  input  logic [XLEN-1:0]         opa_i,
  input  logic [$clog2(XLEN)-1:0] shamt_i,
  input  alu_pkg::alu_ctrl_t      ctrl_i,
  output logic [XLEN-1:0]         shift_o
);

  logic [XLEN-1:0] opa_rev;
  logic [XLEN-1:0] shift_in;
  logic [XLEN:0]   shift_ext;
  logic [XLEN:0]   shift_right;
  logic [XLEN-1:0] shift_right_rev;

  // Bit reversal on the way in and on the way out
  for (genvar k = 0; k < XLEN; k++) begin : g_rev
    assign opa_rev[k]         = opa_i[XLEN-1-k];
    assign shift_right_rev[k] = shift_right[XLEN-1-k];
  end

  // Left shift is a right shift of the reversed operand
  assign shift_in = ctrl_i.shift_left ? opa_rev : opa_i;

  // --------------------------------------------------
  // Single right shifter
  // --------------------------------------------------
  // Fill bit is the sign only for SRA
  assign shift_ext   = {ctrl_i.shift_arith & shift_in[XLEN-1], shift_in};
  assign shift_right = $unsigned($signed(shift_ext) >>> shamt_i);

  assign shift_o = ctrl_i.shift_left ? shift_right_rev : shift_right[XLEN-1:0];

endmodule

`default_nettype wire

/* alu_core/alu_adder.sv */
`default_nettype none

module alu_adder #(
  parameter int unsigned XLEN = alu_pkg::ALU_XLEN_DEFAULT
) (
  input  logic [XLEN-1:0]    opa_i,
  input  logic [XLEN-1:0]    opb_i,
  input  alu_pkg::alu_ctrl_t ctrl_i,
  input  alu_pkg::alu_op_e   op_i,
  output logic [XLEN-1:0]    sum_o,
  output logic [XLEN-1:0]    opb_neg_o,
  output logic               less_o,
  output logic               branch_taken_o
);

  logic [XLEN:0] in_a;
  logic [XLEN:0] in_b;
  logic [XLEN:0] sum_ext;
  logic          zero;

  // Extra low bit turns into the carry in when B is inverted
  assign in_a      = {opa_i, 1'b1};
  assign in_b      = {opb_i, 1'b0} ^ {(XLEN+1){ctrl_i.negate_b}};
  assign sum_ext   = in_a + in_b;
  assign sum_o     = sum_ext[XLEN:1];
  assign opb_neg_o = in_b[XLEN:1];
  assign zero      = ~|sum_o;

  // One extra sign bit covers both signed and unsigned compare
  assign less_o = $signed({ctrl_i.is_signed & opa_i[XLEN-1], opa_i}) <
                  $signed({ctrl_i.is_signed & opb_i[XLEN-1], opb_i});

  // Branch resolution
  always_comb begin
    case (op_i)
      alu_pkg::EQ:                branch_taken_o = zero;
      alu_pkg::NE:                branch_taken_o = ~zero;
      alu_pkg::LTS, alu_pkg::LTU: branch_taken_o = less_o;
      alu_pkg::GES, alu_pkg::GEU: branch_taken_o = ~less_o;
      default:                    branch_taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* common/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  localparam int unsigned ALU_XLEN_DEFAULT = 32;

  // --------------------------------------------------
  // Operation codes
  // --------------------------------------------------
  // Codes above CPOP are illegal and give a zero result
  typedef enum logic [4:0] {
    ADD   = 5'd0,
    SUB   = 5'd1,
    AND_L = 5'd2,
    OR_L  = 5'd3,
    XOR_L = 5'd4,
    ANDN  = 5'd5,
    ORN   = 5'd6,
    XNOR  = 5'd7,
    SLL   = 5'd8,
    SRL   = 5'd9,
    SRA   = 5'd10,
    SLTS  = 5'd11,
    SLTU  = 5'd12,
    MIN   = 5'd13,
    MAX   = 5'd14,
    MINU  = 5'd15,
    MAXU  = 5'd16,
    EQ    = 5'd17,
    NE    = 5'd18,
    LTS   = 5'd19,
    LTU   = 5'd20,
    GES   = 5'd21,
    GEU   = 5'd22,
    CLZ   = 5'd23,
    CTZ   = 5'd24,
    CPOP  = 5'd25
  } alu_op_e;

  // Register map, byte offsets
  localparam logic [4:0] REG_OPA    = 5'h00;
  localparam logic [4:0] REG_OPB    = 5'h04;
  localparam logic [4:0] REG_OP     = 5'h08;
  localparam logic [4:0] REG_RESULT = 5'h0C;
  localparam logic [4:0] REG_BRANCH = 5'h10;

  // --------------------------------------------------
  // Bus and control structs
  // --------------------------------------------------
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [4:0]  adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // Which datapath output reaches the result
  typedef enum logic [2:0] {
    GRP_ADDER,
    GRP_LOGIC,
    GRP_SHIFT,
    GRP_SLT,
    GRP_MIN,
    GRP_MAX,
    GRP_COUNT,
    GRP_ZERO
  } alu_grp_e;

  typedef struct packed {
    logic     negate_b;
    logic     is_signed;
    logic     shift_left;
    logic     shift_arith;
    logic     count_trailing;
    alu_grp_e res_grp;
  } alu_ctrl_t;

endpackage

`default_nettype wire
